// ==== flist.f ====
verilog/cordic_pkg.sv
verilog/cordic_angle_rom.sv
verilog/cordic_req_ctrl.sv
verilog/cordic_iter_core.sv
verilog/cordic_result_stage.sv
verilog/cordic_top.sv
tests/tb_cordic.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the CORDIC testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing -Wno-fatal \
        --top-module tb_cordic -f flist.f -o tb_cordic; then
    echo "verilator build failed"
    exit 1
fi

sim_output="$(./obj_dir/tb_cordic 2>&1)"
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "STATUS: PASS" <<< "$sim_output"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== tests/tb_cordic.sv ====
`timescale 1ns/1ps

module tb_cordic;
    import cordic_pkg::*;

    localparam int  ITERATIONS   = 16;
    localparam int  RESET_CYCLES = 16;
    localparam int  NUM_TRANS    = 46;  // 17 rotation, 15 vectoring, 13 division, 1 back-pressure
    localparam int  MAX_CYCLES   = RESET_CYCLES + 40 * NUM_TRANS + 500;
    localparam int  ACK_LATENCY  = ITERATIONS + 3;  // load, iterations, capture, ack
    localparam int  ACK_WAIT     = 100;
    localparam int  HOLD_CYCLES  = 20;
    localparam real TOL_LSB      = 48.0;
    localparam real SCALE        = 65536.0;  // Q16.16

    logic       clk = 1'b0;
    logic       rst;
    logic       req;
    cordic_op_t op;
    data_t      x_in, y_in, z_in;
    logic       ack;
    data_t      x_out, y_out, z_out;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle_cnt    = 0;
    int seed_val;

    real rot_angles [7] = '{0.0, 0.5, -0.5, 1.0, -1.0, 1.5, -1.5};
    real vec_x [5] = '{1.0, 3.0, 2.0, 100.0, 0.25};
    real vec_y [5] = '{0.0, 4.0, -2.0, -100.0, 0.75};
    real lin_x [3] = '{1.0, 2.0, 100.0};
    real lin_y [3] = '{0.5, -3.0, -150.0};

    cordic_top #(
        .ITERATIONS(ITERATIONS)
    ) uut (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .op   (op),
        .x_in (x_in),
        .y_in (y_in),
        .z_in (z_in),
        .ack  (ack),
        .x_out(x_out),
        .y_out(y_out),
        .z_out(z_out)
    );

    always #50 clk = ~clk;

    ack_with_req : assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else begin
            $display("ack rose while req was low");
            errors++;
        end

    outputs_held : assert property (@(posedge clk) disable iff (rst)
        ack && req |=> $stable(x_out) && $stable(y_out) && $stable(z_out))
        else begin
            $display("results changed while ack and req were both high");
            errors++;
        end

    // run limit on the whole simulation
    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the run did not finish", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic data_t to_fixed(input real r);
        return data_t'($rtoi(r * SCALE));
    endfunction

    function automatic real to_real(input data_t v);
        return $itor(v) / SCALE;
    endfunction

    task automatic check_exact(input string name, input string what, input int expected,
                               input int actual);
        assert (actual == expected) else begin
            $display("** Error %s %s: expected %0d actual %0d", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input string what, input real expected,
                               input data_t actual, input real tol_lsb);
        real diff_lsb;
        diff_lsb = (to_real(actual) - expected) * SCALE;
        if (diff_lsb < 0.0) begin
            diff_lsb = -diff_lsb;
        end
        assert (diff_lsb <= tol_lsb) else begin
            $display("** Error %s %s: expected %0.6f actual %0.6f", name, what, expected,
                     to_real(actual));
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    // one four-phase transaction with results taken at the ack rise
    task automatic run_op(input string name, input cordic_op_t op_v, input data_t x_v,
                          input data_t y_v, input data_t z_v, input int hold,
                          output data_t x_r, output data_t y_r, output data_t z_r);
        int edges;
        @(posedge clk);
        req  <= 1'b1;
        op   <= op_v;
        x_in <= x_v;
        y_in <= y_v;
        z_in <= z_v;
        edges = 0;
        do begin
            @(posedge clk);  // first pass is the edge that samples req high
            edges++;
            @(negedge clk);
        end while (!ack && edges < ACK_WAIT);
        if (!ack) begin
            $display("%s: no ack within %0d cycles", name, ACK_WAIT);
            errors++;
        end
        check_exact(name, "ack latency in edges", ACK_LATENCY, edges);
        x_r = x_out;
        y_r = y_out;
        z_r = z_out;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_exact(name, "ack during hold", 1, ack);
            check_exact(name, "x_out during hold", x_r, x_out);
            check_exact(name, "y_out during hold", y_r, y_out);
            check_exact(name, "z_out during hold", z_r, z_out);
        end
        @(posedge clk);
        req <= 1'b0;
        @(posedge clk);  // samples req low
        @(negedge clk);
        check_exact(name, "ack after req low", 0, ack);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    task automatic rotate_once(input string name, input data_t z_v, input int hold);
        data_t xr, yr, zr;
        real   ang;
        ang = to_real(z_v);
        // junk on x_in and y_in that rotation must ignore
        run_op(name, op_rot_circ, data_t'($urandom), data_t'($urandom), z_v, hold, xr, yr, zr);
        check_value(name, "x_out", $cos(ang), xr, TOL_LSB);
        check_value(name, "y_out", $sin(ang), yr, TOL_LSB);
    endtask

    task automatic vector_once(input string name, input data_t x_v, input data_t y_v);
        data_t xr, yr, zr;
        real   mag;
        real   ang;
        real   tol;
        run_op(name, op_vec_circ, x_v, y_v, '0, 0, xr, yr, zr);
        mag = $sqrt(to_real(x_v) * to_real(x_v) + to_real(y_v) * to_real(y_v));
        ang = $atan2(to_real(y_v), to_real(x_v));
        tol = TOL_LSB + 1.0e-3 * mag * SCALE;
        check_value(name, "x_out", mag, xr, tol);
        check_value(name, "y_out", 0.0, yr, tol);
        check_value(name, "z_out", ang, zr, TOL_LSB + 1.0e-3 * (ang < 0.0 ? -ang : ang) * SCALE);
    endtask

    task automatic divide_once(input string name, input data_t x_v, input data_t y_v);
        data_t xr, yr, zr;
        run_op(name, op_vec_lin, x_v, y_v, '0, 0, xr, yr, zr);
        check_exact(name, "x_out", x_v, xr);  // linear mode leaves x untouched
        check_value(name, "z_out", to_real(y_v) / to_real(x_v), zr, TOL_LSB);
    endtask

    initial begin
        int    e0;
        data_t xv;
        data_t rv;
        seed_val = $urandom(32'hdf6e_bb38);
        rst  = 1'b1;
        req  = 1'b0;
        op   = op_rot_circ;
        x_in = '0;
        y_in = '0;
        z_in = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        e0 = errors;
        check_exact("reset_state", "ack", 0, ack);
        check_exact("reset_state", "x_out", 0, x_out);
        check_exact("reset_state", "y_out", 0, y_out);
        check_exact("reset_state", "z_out", 0, z_out);
        report_test("reset_state", e0);

        e0 = errors;
        for (int i = 0; i < 7; i++) begin
            rotate_once($sformatf("rot_fixed[%0d]", i), to_fixed(rot_angles[i]), 0);
        end
        report_test("rot_fixed", e0);

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            rotate_once($sformatf("rot_random[%0d]", i), int'($urandom % 32'd196609) - 98304, 0);
        end
        report_test("rot_random", e0);

        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            vector_once($sformatf("vec_fixed[%0d]", i), to_fixed(vec_x[i]), to_fixed(vec_y[i]));
        end
        report_test("vec_fixed", e0);

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            xv = 6554 + int'($urandom % 32'd6547047);  // 0.1 to 100
            vector_once($sformatf("vec_random[%0d]", i), xv,
                        int'($urandom % 32'd13107201) - 6553600);
        end
        report_test("vec_random", e0);

        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            divide_once($sformatf("lin_fixed[%0d]", i), to_fixed(lin_x[i]), to_fixed(lin_y[i]));
        end
        report_test("lin_fixed", e0);

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            xv = 32768 + int'($urandom % 32'd6520833);  // 0.5 to 100
            rv = int'($urandom % 32'd242483) - 121241;  // ratio within 1.85
            divide_once($sformatf("lin_random[%0d]", i), xv,
                        data_t'((longint'(xv) * longint'(rv)) >>> 16));
        end
        report_test("lin_random", e0);

        e0 = errors;
        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
            check_exact("handshake", "ack while idle", 0, ack);
        end
        rotate_once("handshake", to_fixed(0.75), HOLD_CYCLES);
        report_test("handshake", e0);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/cordic_angle_rom.sv ====
`timescale 1ns/1ps

module cordic_angle_rom (
    input  cordic_pkg::iter_idx_t idx,
    input  logic                  linear,
    output cordic_pkg::data_t     alpha
);

    always_comb begin
        if (linear) begin
            case (idx)  // 2^-idx
                4'd0:  alpha = 32'sd65536;
                4'd1:  alpha = 32'sd32768;
                4'd2:  alpha = 32'sd16384;
                4'd3:  alpha = 32'sd8192;
                4'd4:  alpha = 32'sd4096;
                4'd5:  alpha = 32'sd2048;
                4'd6:  alpha = 32'sd1024;
                4'd7:  alpha = 32'sd512;
                4'd8:  alpha = 32'sd256;
                4'd9:  alpha = 32'sd128;
                4'd10: alpha = 32'sd64;
                4'd11: alpha = 32'sd32;
                4'd12: alpha = 32'sd16;
                4'd13: alpha = 32'sd8;
                4'd14: alpha = 32'sd4;
                default: alpha = 32'sd2;  // index 15
            endcase
        end else begin
            case (idx)  // atan(2^-idx)
                4'd0:  alpha = 32'sd51472;  // pi/4
                4'd1:  alpha = 32'sd30386;
                4'd2:  alpha = 32'sd16055;
                4'd3:  alpha = 32'sd8150;
                4'd4:  alpha = 32'sd4090;
                4'd5:  alpha = 32'sd2047;
                4'd6:  alpha = 32'sd1023;
                4'd7:  alpha = 32'sd511;
                4'd8:  alpha = 32'sd255;
                4'd9:  alpha = 32'sd127;
                4'd10: alpha = 32'sd63;
                4'd11: alpha = 32'sd31;
                4'd12: alpha = 32'sd15;
                4'd13: alpha = 32'sd7;
                4'd14: alpha = 32'sd3;
                default: alpha = 32'sd1;  // index 15
            endcase
        end
    end

endmodule

// ==== verilog/cordic_iter_core.sv ====
`timescale 1ns/1ps

module cordic_iter_core #(
    parameter int ITERATIONS = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  cordic_pkg::cordic_op_t op,
    input  cordic_pkg::data_t      init_x,
    input  cordic_pkg::data_t      init_y,
    input  cordic_pkg::data_t      init_z,
    output logic                   done,
    output cordic_pkg::data_t      x_res,
    output cordic_pkg::data_t      y_res,
    output cordic_pkg::data_t      z_res
);
    import cordic_pkg::*;

    data_t     x_q, y_q, z_q;
    data_t     x_cur, y_cur, z_cur;
    data_t     x_sh, y_sh;
    data_t     alpha;
    data_t     x_nxt, y_nxt, z_nxt;
    iter_idx_t cnt;
    logic      busy;
    logic      linear;
    logic      sigma_pos;
    logic      last;

    if (ITERATIONS < 8 || ITERATIONS > MAX_ITERATIONS) begin : g_iter_range
        $error("ITERATIONS must lie between 8 and %0d", MAX_ITERATIONS);
    end

    assign linear = (op == op_vec_lin);
    assign last   = (cnt == iter_idx_t'(ITERATIONS - 1));

    // step 0 works straight from the initial values
    assign x_cur = start ? init_x : x_q;
    assign y_cur = start ? init_y : y_q;
    assign z_cur = start ? init_z : z_q;

    assign x_sh = x_cur >>> cnt;  // arithmetic, data_t is signed
    assign y_sh = y_cur >>> cnt;

    cordic_angle_rom u_rom (
        .idx   (cnt),
        .linear(linear),
        .alpha (alpha)
    );

    always_comb begin
        if (op == op_rot_circ) begin
            sigma_pos = !z_cur[31];  // drive z toward zero
        end else begin
            sigma_pos = (x_cur[31] != y_cur[31]);  // drive y toward zero
        end
    end

    always_comb begin
        if (linear) begin
            x_nxt = x_cur;
        end else begin
            x_nxt = sigma_pos ? x_cur - y_sh : x_cur + y_sh;
        end
        y_nxt = sigma_pos ? y_cur + x_sh : y_cur - x_sh;
        z_nxt = sigma_pos ? z_cur - alpha : z_cur + alpha;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start || busy) begin
                if (last) begin
                    busy <= 1'b0;
                    cnt  <= '0;  // ready for the next start
                    done <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    cnt  <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            x_q <= x_nxt;
            y_q <= y_nxt;
            z_q <= z_nxt;
        end
    end

    assign x_res = x_q;
    assign y_res = y_q;
    assign z_res = z_q;

    a_cnt_bound : assert property (@(posedge clk) disable iff (rst)
        busy |-> cnt < ITERATIONS)
        else $error("iteration counter ran past ITERATIONS");

    a_done_latency : assert property (@(posedge clk) disable iff (rst)
        start |-> ##(ITERATIONS) done)
        else $error("done not seen ITERATIONS cycles after start");

endmodule

// ==== verilog/cordic_pkg.sv ====
package cordic_pkg;

    // signed Q16.16 operand or result
    typedef logic signed [31:0] data_t;

    // operation select; code 2'b11 is not a legal operation
    typedef enum logic [1:0] {
        op_rot_circ = 2'b00,  // cos / sin of z_in
        op_vec_circ = 2'b01,  // magnitude and atan(y/x)
        op_vec_lin  = 2'b10   // quotient y/x in z
    } cordic_op_t;

    typedef logic [3:0] iter_idx_t;  // micro-rotation index

    localparam int FRAC_BITS      = 16;  // Q16.16
    localparam int MAX_ITERATIONS = 16;  // entries in the angle table

    // 1/K for the circular mode, 0.6072529 * 2^16
    localparam data_t K_INV_CIRC = 32'sd39797;

endpackage

// ==== verilog/cordic_req_ctrl.sv ====
`timescale 1ns/1ps

module cordic_req_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  cordic_pkg::cordic_op_t op,
    input  cordic_pkg::data_t      x_in,
    input  cordic_pkg::data_t      y_in,
    input  cordic_pkg::data_t      z_in,
    input  logic                   done,
    output logic                   ack,
    output logic                   start,
    output cordic_pkg::cordic_op_t op_q,
    output cordic_pkg::data_t      init_x,
    output cordic_pkg::data_t      init_y,
    output cordic_pkg::data_t      init_z
);
    import cordic_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_busy,
        st_hold
    } state_t;

    state_t state;
    logic   accept;

    assign accept = (state == st_idle) && req;  // new request seen in idle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            start <= 1'b0;
            ack   <= 1'b0;
            op_q  <= op_rot_circ;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_load;
                        start <= 1'b1;  // high for the whole load cycle
                        op_q  <= op;
                    end
                end
                st_load: begin
                    start <= 1'b0;
                    state <= st_busy;
                end
                st_busy: begin
                    if (done) begin
                        state <= st_hold;  // result stage captures on this edge
                    end
                end
                st_hold: begin
                    // ack follows req here, so it drops on the edge that sees req low
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                    start <= 1'b0;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // operand latch, loaded together with the move into load
    always_ff @(posedge clk) begin
        if (accept) begin
            if (op == op_rot_circ) begin
                init_x <= K_INV_CIRC;  // pre-scaled unit vector
                init_y <= '0;
            end else begin
                init_x <= x_in;
                init_y <= y_in;
            end
            init_z <= z_in;
        end
    end

    a_op_legal : assert property (@(posedge clk) disable iff (rst)
        req |-> op inside {op_rot_circ, op_vec_circ, op_vec_lin})
        else $error("illegal op code while req is high");

    a_start_in_load : assert property (@(posedge clk) disable iff (rst)
        start |-> state == st_load && $past(state) == st_idle)
        else $error("start outside the load step");

endmodule

// ==== verilog/cordic_result_stage.sv ====
`timescale 1ns/1ps

module cordic_result_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   done,
    input  cordic_pkg::cordic_op_t op,
    input  cordic_pkg::data_t      x_res,
    input  cordic_pkg::data_t      y_res,
    input  cordic_pkg::data_t      z_res,
    output cordic_pkg::data_t      x_out,
    output cordic_pkg::data_t      y_out,
    output cordic_pkg::data_t      z_out
);
    import cordic_pkg::*;

    data_t               x_abs;
    logic signed [63:0]  x_wide;
    logic signed [63:0]  k_wide;
    logic signed [63:0]  mag_prod;
    data_t               mag;

    assign x_abs    = x_res[31] ? -x_res : x_res;
    assign x_wide   = x_abs;       // sign extended
    assign k_wide   = K_INV_CIRC;
    assign mag_prod = x_wide * k_wide;
    assign mag      = mag_prod[FRAC_BITS +: 32];  // back to Q16.16

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_out <= '0;
            y_out <= '0;
            z_out <= '0;
        end else if (done) begin
            // only the vectoring magnitude still carries the CORDIC gain
            x_out <= (op == op_vec_circ) ? mag : x_res;
            y_out <= y_res;
            z_out <= z_res;
        end
    end

    a_mag_sign : assert property (@(posedge clk) disable iff (rst)
        done && op == op_vec_circ |=> !x_out[31])
        else $error("negative magnitude after circular vectoring");

endmodule

// ==== verilog/cordic_top.sv ====
`timescale 1ns/1ps

module cordic_top #(
    parameter int ITERATIONS = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  cordic_pkg::cordic_op_t op,
    input  cordic_pkg::data_t      x_in,
    input  cordic_pkg::data_t      y_in,
    input  cordic_pkg::data_t      z_in,
    output logic                   ack,
    output cordic_pkg::data_t      x_out,
    output cordic_pkg::data_t      y_out,
    output cordic_pkg::data_t      z_out
);
    import cordic_pkg::*;

    logic       start;
    logic       done;
    cordic_op_t op_q;  // stable from start until the next start
    data_t      init_x, init_y, init_z;
    data_t      x_res, y_res, z_res;

    cordic_req_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .op    (op),
        .x_in  (x_in),
        .y_in  (y_in),
        .z_in  (z_in),
        .done  (done),
        .ack   (ack),
        .start (start),
        .op_q  (op_q),
        .init_x(init_x),
        .init_y(init_y),
        .init_z(init_z)
    );

    cordic_iter_core #(
        .ITERATIONS(ITERATIONS)
    ) u_core (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .op    (op_q),
        .init_x(init_x),
        .init_y(init_y),
        .init_z(init_z),
        .done  (done),
        .x_res (x_res),
        .y_res (y_res),
        .z_res (z_res)
    );

    cordic_result_stage u_result (
        .clk  (clk),
        .rst  (rst),
        .done (done),
        .op   (op_q),
        .x_res(x_res),
        .y_res(y_res),
        .z_res(z_res),
        .x_out(x_out),
        .y_out(y_out),
        .z_out(z_out)
    );

endmodule
